//--- Makefile
SIM      = verilator
FLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP      = tb_ycr_dmem_top
FILELIST = ycr_dmem_cluster.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and look for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@if ./obj_dir/V$(TOP) | tee /dev/stderr | grep "Test completed successfully" > /dev/null; then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir

//--- bench/tb_ycr_dmem_top.sv
`timescale 1ns/1ps

module tb_ycr_dmem_top;

    // Cycle budget, fill pass plus random and timer phases with wide margin
    localparam int unsigned TIMEOUT_CYCLES = 20000;
    localparam int unsigned ACK_LIMIT      = 8;
    localparam int unsigned RTC_HOLD       = 6;
    localparam int unsigned DRV_DLY        = 2;

    logic                    clk;
    logic                    arst_n_i;
    logic                    rtc_clk_i;
    logic                    req_i;
    ycr_dmem_pkg::dmem_req_t req_data_i;
    logic                    req_ack_o;
    ycr_dmem_pkg::dmem_rsp_t rsp_o;
    ycr_dmem_pkg::mtime_t    timer_val_o;
    logic                    timer_irq_o;

    // Reference state
    logic [31:0]             tcm_model [0:ycr_dmem_pkg::TCM_WORDS-1];
    ycr_dmem_pkg::mtime_t    mtime_model;
    // Responses waiting for the compare process
    ycr_dmem_pkg::dmem_rsp_t got_q [$];
    ycr_dmem_pkg::dmem_rsp_t exp_q [$];
    bit                      data_q [$];
    string                   what_q [$];
    int unsigned             cycle_cnt = 0;

    ycr_dmem_top uut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rtc_clk_i   (rtc_clk_i),
        .req_i       (req_i),
        .req_data_i  (req_data_i),
        .req_ack_o   (req_ack_o),
        .rsp_o       (rsp_o),
        .timer_val_o (timer_val_o),
        .timer_irq_o (timer_irq_o)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------------------------------------
    // Error exit and compare tasks
    // --------------------------------------------------
    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_rsp(
        input ycr_dmem_pkg::dmem_rsp_t got,
        input ycr_dmem_pkg::dmem_rsp_t exp,
        input bit                      chk_data,
        input string                   what
    );
        // rdata only counts on a read that went ready-ok
        if (got.resp !== exp.resp || (chk_data && got.rdata !== exp.rdata)) begin
            stop_on_error($sformatf("Fail at time %0t: %s, got %0d/%h, expected %0d/%h",
                                    $time, what, got.resp, got.rdata, exp.resp, exp.rdata));
        end
    endtask

    task automatic check_mtime(
        input ycr_dmem_pkg::mtime_t got,
        input ycr_dmem_pkg::mtime_t exp,
        input string                what
    );
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at time %0t: %s, got %h, expected %h",
                                    $time, what, got, exp));
        end
    endtask

    task automatic check_irq(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("Fail at time %0t: %s, got %b, expected %b",
                                    $time, what, got, exp));
        end
    endtask

    // New TCM word after a write of the given width
    function automatic logic [31:0] ref_tcm_merge(
        input logic [31:0]              old_word,
        input logic [31:0]              wdata,
        input ycr_dmem_pkg::mem_width_e width,
        input logic [31:0]              addr
    );
        logic [31:0] new_word;
        logic        lane_hit;
        new_word = old_word;
        for (int lane = 0; lane < 4; lane++) begin
            case (width)
                ycr_dmem_pkg::MEM_WIDTH_BYTE:  lane_hit = (lane == int'(addr[1:0]));
                ycr_dmem_pkg::MEM_WIDTH_HWORD: lane_hit = ((lane / 2) == int'(addr[1]));
                default:                       lane_hit = 1'b1;
            endcase
            if (lane_hit) begin
                new_word[8*lane +: 8] = wdata[8*lane +: 8];
            end
        end
        return new_word;
    endfunction

    // --------------------------------------------------
    // Bus access and rtc stimulus
    // --------------------------------------------------
    task automatic access(
        input ycr_dmem_pkg::mem_cmd_e   cmd,
        input ycr_dmem_pkg::mem_width_e width,
        input logic [31:0]              addr,
        input logic [31:0]              wdata,
        input ycr_dmem_pkg::mem_resp_e  exp_resp,
        input logic [31:0]              exp_data,
        input bit                       chk_data,
        input string                    what
    );
        ycr_dmem_pkg::dmem_rsp_t exp;
        int unsigned             waited;
        exp.resp  = exp_resp;
        exp.rdata = exp_data;
        waited    = 0;
        @(posedge clk);
        #(DRV_DLY);
        req_i            = 1'b1;
        req_data_i.cmd   = cmd;
        req_data_i.width = width;
        req_data_i.addr  = addr;
        req_data_i.wdata = wdata;
        // Ack is combinational, look mid-cycle
        @(negedge clk);
        while (req_ack_o !== 1'b1) begin
            waited++;
            if (waited >= ACK_LIMIT) begin
                stop_on_error($sformatf("No acknowledge within %0d cycles for %s",
                                        ACK_LIMIT, what));
            end
            @(negedge clk);
        end
        @(posedge clk);
        #(DRV_DLY);
        req_i = 1'b0;
        // Response sits in the cycle after the ack
        @(negedge clk);
        got_q.push_back(rsp_o);
        exp_q.push_back(exp);
        data_q.push_back(chk_data);
        what_q.push_back(what);
    endtask

    task automatic tcm_op(
        input ycr_dmem_pkg::mem_cmd_e   cmd,
        input ycr_dmem_pkg::mem_width_e width,
        input logic [31:0]              addr,
        input logic [31:0]              wdata
    );
        logic [ycr_dmem_pkg::TCM_IDX_W-1:0] idx;
        idx = addr[ycr_dmem_pkg::TCM_IDX_W+1:2];
        if (cmd == ycr_dmem_pkg::MEM_CMD_WR) begin
            access(cmd, width, addr, wdata, ycr_dmem_pkg::MEM_RESP_RDY_OK, '0, 1'b0,
                   "TCM write");
            tcm_model[idx] = ref_tcm_merge(tcm_model[idx], wdata, width, addr);
        end else begin
            access(cmd, width, addr, '0, ycr_dmem_pkg::MEM_RESP_RDY_OK, tcm_model[idx], 1'b1,
                   "TCM read");
        end
    endtask

    function automatic logic [31:0] tmr_addr(input logic [4:0] ofs);
        return ycr_dmem_pkg::TIMER_ADDR_PATTERN | {27'b0, ofs};
    endfunction

    task automatic timer_wr(input logic [4:0] ofs, input logic [31:0] data);
        access(ycr_dmem_pkg::MEM_CMD_WR, ycr_dmem_pkg::MEM_WIDTH_WORD, tmr_addr(ofs), data,
               ycr_dmem_pkg::MEM_RESP_RDY_OK, '0, 1'b0, "timer write");
    endtask

    task automatic timer_rd(input logic [4:0] ofs, input logic [31:0] exp, input string what);
        access(ycr_dmem_pkg::MEM_CMD_RD, ycr_dmem_pkg::MEM_WIDTH_WORD, tmr_addr(ofs), '0,
               ycr_dmem_pkg::MEM_RESP_RDY_OK, exp, 1'b1, what);
    endtask

    // Full rtc periods, each level held RTC_HOLD clk cycles
    task automatic rtc_edges(input int unsigned n);
        repeat (n) begin
            repeat (RTC_HOLD) @(posedge clk);
            #(DRV_DLY);
            rtc_clk_i = 1'b1;
            repeat (RTC_HOLD) @(posedge clk);
            #(DRV_DLY);
            rtc_clk_i = 1'b0;
        end
    endtask

    // Compare process, drains captured responses each edge
    always @(posedge clk) begin
        while (got_q.size() != 0) begin
            check_rsp(got_q.pop_front(), exp_q.pop_front(), data_q.pop_front(),
                      what_q.pop_front());
        end
        if (uut.i_sva.fail_cnt != 0) begin
            stop_on_error("A handshake assertion in the bound checker failed");
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("Timeout, run still going after %0d cycles", cycle_cnt));
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        logic [31:0]              addr;
        ycr_dmem_pkg::mem_width_e width;
        ycr_dmem_pkg::mtime_t     cmp;
        void'($urandom(77));
        arst_n_i    = 1'b0;
        rtc_clk_i   = 1'b0;
        req_i       = 1'b0;
        req_data_i  = '0;
        mtime_model = '0;
        repeat (10) @(posedge clk);
        #(DRV_DLY);
        arst_n_i = 1'b1;

        // Fill every TCM word, pattern from the full address
        for (int i = 0; i < ycr_dmem_pkg::TCM_WORDS; i++) begin
            addr = ycr_dmem_pkg::TCM_ADDR_PATTERN + 32'(i * 4);
            tcm_op(ycr_dmem_pkg::MEM_CMD_WR, ycr_dmem_pkg::MEM_WIDTH_WORD, addr,
                   addr ^ 32'h5A3C_96E1);
        end
        // Random mixed-width traffic, aligned
        repeat (200) begin
            width = ycr_dmem_pkg::mem_width_e'(2'($urandom_range(0, 2)));
            addr  = ycr_dmem_pkg::TCM_ADDR_PATTERN | ($urandom() & 32'hFFF);
            if (width != ycr_dmem_pkg::MEM_WIDTH_BYTE) begin
                addr[0] = 1'b0;
            end
            if (width == ycr_dmem_pkg::MEM_WIDTH_WORD) begin
                addr[1] = 1'b0;
            end
            tcm_op(ycr_dmem_pkg::mem_cmd_e'(1'($urandom())), width, addr, $urandom());
        end

        // Router errors, aimed-at word must survive
        access(ycr_dmem_pkg::MEM_CMD_RD, ycr_dmem_pkg::MEM_WIDTH_WORD, 32'h0050_0000, '0,
               ycr_dmem_pkg::MEM_RESP_RDY_ER, '0, 1'b0, "unmapped read");
        access(ycr_dmem_pkg::MEM_CMD_WR, ycr_dmem_pkg::MEM_WIDTH_WORD, 32'h0048_1000,
               32'hDEAD_BEEF, ycr_dmem_pkg::MEM_RESP_RDY_ER, '0, 1'b0, "unmapped write");
        access(ycr_dmem_pkg::MEM_CMD_WR, ycr_dmem_pkg::MEM_WIDTH_HWORD, 32'h0048_0101,
               32'hFFFF_FFFF, ycr_dmem_pkg::MEM_RESP_RDY_ER, '0, 1'b0, "misaligned halfword");
        access(ycr_dmem_pkg::MEM_CMD_WR, ycr_dmem_pkg::MEM_WIDTH_WORD, 32'h0048_0102,
               32'hFFFF_FFFF, ycr_dmem_pkg::MEM_RESP_RDY_ER, '0, 1'b0, "misaligned word");
        tcm_op(ycr_dmem_pkg::MEM_CMD_RD, ycr_dmem_pkg::MEM_WIDTH_WORD, 32'h0048_0100, '0);

        // Counting across the low-word carry
        timer_wr(ycr_dmem_pkg::TIMER_MTIME_LO_OFS, 32'hFFFF_FFFD);
        mtime_model[31:0] = 32'hFFFF_FFFD;
        rtc_edges(5);
        mtime_model += 64'd5;
        timer_rd(ycr_dmem_pkg::TIMER_MTIME_LO_OFS, mtime_model[31:0], "mtime low");
        timer_rd(ycr_dmem_pkg::TIMER_MTIME_HI_OFS, mtime_model[63:32], "mtime high");
        check_mtime(timer_val_o, mtime_model, "timer value after counting");
        // Disabled, edges ignored
        timer_wr(ycr_dmem_pkg::TIMER_CTRL_OFS, 32'h0);
        rtc_edges(3);
        timer_rd(ycr_dmem_pkg::TIMER_MTIME_LO_OFS, mtime_model[31:0], "mtime low disabled");
        check_mtime(timer_val_o, mtime_model, "timer value disabled");
        timer_wr(ycr_dmem_pkg::TIMER_CTRL_OFS, 32'h1);
        timer_rd(ycr_dmem_pkg::TIMER_CTRL_OFS, 32'h1, "control readback");

        // Interrupt three edges ahead, low half first keeps compare high
        cmp = mtime_model + 64'd3;
        timer_wr(ycr_dmem_pkg::TIMER_MTIMECMP_LO_OFS, cmp[31:0]);
        timer_wr(ycr_dmem_pkg::TIMER_MTIMECMP_HI_OFS, cmp[63:32]);
        check_irq(timer_irq_o, 1'b0, "irq before any edge");
        for (int e = 1; e <= 3; e++) begin
            rtc_edges(1);
            mtime_model += 64'd1;
            check_irq(timer_irq_o, e == 3, "irq around the compare match");
        end
        timer_wr(ycr_dmem_pkg::TIMER_CTRL_OFS, 32'h0);
        repeat (2) @(posedge clk);
        check_irq(timer_irq_o, 1'b0, "irq after enable cleared");
        timer_wr(ycr_dmem_pkg::TIMER_MTIMECMP_HI_OFS, 32'hFFFF_FFFF);
        timer_wr(ycr_dmem_pkg::TIMER_MTIMECMP_LO_OFS, 32'hFFFF_FFFF);
        timer_wr(ycr_dmem_pkg::TIMER_CTRL_OFS, 32'h1);
        repeat (2) @(posedge clk);
        check_irq(timer_irq_o, 1'b0, "irq with compare at all ones");

        // Timer access errors change nothing
        access(ycr_dmem_pkg::MEM_CMD_RD, ycr_dmem_pkg::MEM_WIDTH_BYTE, tmr_addr(5'h08), '0,
               ycr_dmem_pkg::MEM_RESP_RDY_ER, '0, 1'b0, "byte read at timer");
        access(ycr_dmem_pkg::MEM_CMD_WR, ycr_dmem_pkg::MEM_WIDTH_HWORD, tmr_addr(5'h10), '0,
               ycr_dmem_pkg::MEM_RESP_RDY_ER, '0, 1'b0, "halfword write at timer");
        access(ycr_dmem_pkg::MEM_CMD_RD, ycr_dmem_pkg::MEM_WIDTH_WORD, tmr_addr(5'h04), '0,
               ycr_dmem_pkg::MEM_RESP_RDY_ER, '0, 1'b0, "unused timer offset");
        timer_rd(ycr_dmem_pkg::TIMER_MTIMECMP_LO_OFS, 32'hFFFF_FFFF, "mtimecmp low kept");
        // Write mtime low, then two counted edges
        timer_wr(ycr_dmem_pkg::TIMER_MTIME_LO_OFS, 32'h1234_5670);
        mtime_model[31:0] = 32'h1234_5670;
        rtc_edges(2);
        mtime_model += 64'd2;
        timer_rd(ycr_dmem_pkg::TIMER_MTIME_LO_OFS, mtime_model[31:0], "mtime low after write");
        check_mtime(timer_val_o, mtime_model, "timer value after write");

        repeat (2) @(posedge clk);
        if (got_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_on_error("Responses were captured but never compared");
        end
    end

endmodule

//--- bench/ycr_dmem_sva.sv
`timescale 1ns/1ps

module ycr_dmem_sva (
    input logic                    clk,
    input logic                    arst_n_i,
    input logic                    req_i,
    input logic                    req_ack_o,
    input ycr_dmem_pkg::dmem_rsp_t rsp_o,
    input logic                    timer_irq_o
);

    // Assertion failures seen so far
    int unsigned fail_cnt = 0;
    logic        rsp_rdy;

    assign rsp_rdy = (rsp_o.resp != ycr_dmem_pkg::MEM_RESP_NOTRDY);

    // --------------------------------------------------
    // Handshake rules
    // --------------------------------------------------
    // Ack exactly when a request meets a cycle with no response due
    ack_when_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_ack_o == (req_i && !rsp_rdy))
    else begin
        fail_cnt++;
        $error("acknowledge does not match request and response state");
    end

    // Ready response exactly one cycle after each ack
    rsp_after_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
        req_ack_o |=> rsp_rdy)
    else begin
        fail_cnt++;
        $error("no ready response after acknowledge");
    end

    rsp_only_after_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
        rsp_rdy |-> $past(req_ack_o))
    else begin
        fail_cnt++;
        $error("ready response without a preceding acknowledge");
    end

    // Quiet outputs in reset
    reset_quiet: assert property (@(posedge clk)
        !arst_n_i |-> (!rsp_rdy && !timer_irq_o))
    else begin
        fail_cnt++;
        $error("response or interrupt active during reset");
    end

endmodule

bind ycr_dmem_top ycr_dmem_sva i_sva (.*);

//--- verilog/dmem_router.sv
`timescale 1ns/1ps

module dmem_router (
    input  logic                    clk,
    input  logic                    arst_n_i,
    // Requester side
    input  logic                    req_i,
    input  ycr_dmem_pkg::dmem_req_t req_data_i,
    output logic                    req_ack_o,
    output ycr_dmem_pkg::dmem_rsp_t rsp_o,
    // Shared request bus and per-target strobes
    output ycr_dmem_pkg::dmem_req_t tgt_req_o,
    output logic                    tcm_req_o,
    output logic                    timer_req_o,
    // Target responses, one cycle after strobe
    input  ycr_dmem_pkg::dmem_rsp_t tcm_rsp_i,
    input  ycr_dmem_pkg::dmem_rsp_t timer_rsp_i
);

    // Who answers in the next cycle
    typedef enum logic [1:0] {
        PEND_NONE  = 2'b00,
        PEND_TCM   = 2'b01,
        PEND_TIMER = 2'b10,
        PEND_ERR   = 2'b11
    } pend_e;

    pend_e pend_q;
    pend_e pend_d;

    logic  tcm_hit;
    logic  timer_hit;
    logic  misaligned;
    logic  legal_tcm;
    logic  legal_timer;

    // -----------------------------------------------
    // Address decode and alignment check
    // -----------------------------------------------
    always_comb begin
        tcm_hit   = (req_data_i.addr & ycr_dmem_pkg::TCM_ADDR_MASK)
                    == ycr_dmem_pkg::TCM_ADDR_PATTERN;
        timer_hit = (req_data_i.addr & ycr_dmem_pkg::TIMER_ADDR_MASK)
                    == ycr_dmem_pkg::TIMER_ADDR_PATTERN;

        // Halfword on odd byte, or word off a 4-byte boundary
        case (req_data_i.width)
            ycr_dmem_pkg::MEM_WIDTH_HWORD: misaligned = req_data_i.addr[0];
            ycr_dmem_pkg::MEM_WIDTH_WORD:  misaligned = |req_data_i.addr[1:0];
            ycr_dmem_pkg::MEM_WIDTH_BYTE:  misaligned = 1'b0;
            // Reserved width code treated as bad access
            default:                       misaligned = 1'b1;
        endcase

        legal_tcm   = tcm_hit & ~misaligned;
        legal_timer = timer_hit & ~misaligned;
    end

    // Accept only while no response is due this cycle
    assign req_ack_o = req_i & (pend_q == PEND_NONE);

    // One bus to both targets, strobes pick the owner
    assign tgt_req_o   = req_data_i;
    assign tcm_req_o   = req_ack_o & legal_tcm;
    assign timer_req_o = req_ack_o & legal_timer;

    // -----------------------------------------------
    // Pending source register
    // -----------------------------------------------
    always_comb begin
        pend_d = PEND_NONE;
        if (req_ack_o) begin
            if (legal_tcm) begin
                pend_d = PEND_TCM;
            end else if (legal_timer) begin
                pend_d = PEND_TIMER;
            end else begin
                // Unmapped or misaligned, answered locally
                pend_d = PEND_ERR;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pend_q <= PEND_NONE;
        end else begin
            pend_q <= pend_d;
        end
    end

    // -----------------------------------------------
    // Response mux
    // -----------------------------------------------
    always_comb begin
        case (pend_q)
            PEND_TCM:   rsp_o = tcm_rsp_i;
            PEND_TIMER: rsp_o = timer_rsp_i;
            PEND_ERR: begin
                rsp_o.resp  = ycr_dmem_pkg::MEM_RESP_RDY_ER;
                rsp_o.rdata = '0;
            end
            default: begin
                // Idle, nothing owed
                rsp_o.resp  = ycr_dmem_pkg::MEM_RESP_NOTRDY;
                rsp_o.rdata = '0;
            end
        endcase
    end

endmodule

//--- verilog/mtimer.sv
`timescale 1ns/1ps

module mtimer (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    rtc_clk_i,
    // Register access
    input  logic                    req_i,
    input  ycr_dmem_pkg::dmem_req_t req_data_i,
    output ycr_dmem_pkg::dmem_rsp_t rsp_o,
    // Timer outputs
    output ycr_dmem_pkg::mtime_t    timer_val_o,
    output logic                    timer_irq_o
);

    // RTC synchronizer and edge detect
    logic [1:0]                           rtc_sync_q;
    logic                                 rtc_prev_q;
    logic                                 rtc_tick;

    // Timer state
    logic                                 enable_q;
    ycr_dmem_pkg::mtime_t                 mtime_q;
    ycr_dmem_pkg::mtime_t                 mtimecmp_q;
    logic                                 irq_q;

    // Access decode
    logic [4:0]                           ofs;
    logic                                 acc_ok;
    logic                                 wr_en;
    logic [ycr_dmem_pkg::DMEM_DWIDTH-1:0] rd_word;

    ycr_dmem_pkg::mem_resp_e              resp_q;
    logic [ycr_dmem_pkg::DMEM_DWIDTH-1:0] rdata_q;

    // -----------------------------------------------
    // RTC edge detection
    // -----------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rtc_sync_q <= '0;
            rtc_prev_q <= 1'b0;
        end else begin
            rtc_sync_q <= {rtc_sync_q[0], rtc_clk_i};
            rtc_prev_q <= rtc_sync_q[1];
        end
    end

    // Rising edge seen after second sync stage
    assign rtc_tick = rtc_sync_q[1] & ~rtc_prev_q;

    // -----------------------------------------------
    // Register decode, word accesses only
    // -----------------------------------------------
    always_comb begin
        ofs     = req_data_i.addr[4:0];
        acc_ok  = 1'b1;
        rd_word = '0;
        case (ofs)
            ycr_dmem_pkg::TIMER_CTRL_OFS:        rd_word[0] = enable_q;
            ycr_dmem_pkg::TIMER_MTIME_LO_OFS:    rd_word = mtime_q[31:0];
            ycr_dmem_pkg::TIMER_MTIME_HI_OFS:    rd_word = mtime_q[63:32];
            ycr_dmem_pkg::TIMER_MTIMECMP_LO_OFS: rd_word = mtimecmp_q[31:0];
            ycr_dmem_pkg::TIMER_MTIMECMP_HI_OFS: rd_word = mtimecmp_q[63:32];
            // Hole in the map
            default:                             acc_ok = 1'b0;
        endcase
        if (req_data_i.width != ycr_dmem_pkg::MEM_WIDTH_WORD) begin
            acc_ok = 1'b0;
        end
        wr_en = req_i & acc_ok & (req_data_i.cmd == ycr_dmem_pkg::MEM_CMD_WR);
    end

    // -----------------------------------------------
    // Timer registers
    // -----------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q   <= 1'b1;
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            irq_q      <= 1'b0;
        end else begin
            if (wr_en && ofs == ycr_dmem_pkg::TIMER_CTRL_OFS) begin
                enable_q <= req_data_i.wdata[0];
            end
            // Software write wins over a count
            if (wr_en && ofs == ycr_dmem_pkg::TIMER_MTIME_LO_OFS) begin
                mtime_q <= {mtime_q[63:32], req_data_i.wdata};
            end else if (wr_en && ofs == ycr_dmem_pkg::TIMER_MTIME_HI_OFS) begin
                mtime_q <= {req_data_i.wdata, mtime_q[31:0]};
            end else if (rtc_tick && enable_q) begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (wr_en && ofs == ycr_dmem_pkg::TIMER_MTIMECMP_LO_OFS) begin
                mtimecmp_q[31:0] <= req_data_i.wdata;
            end
            if (wr_en && ofs == ycr_dmem_pkg::TIMER_MTIMECMP_HI_OFS) begin
                mtimecmp_q[63:32] <= req_data_i.wdata;
            end
            // Compare result, one cycle behind the registers
            irq_q <= enable_q & (mtime_q >= mtimecmp_q);
        end
    end

    // -----------------------------------------------
    // Access response
    // -----------------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_q <= ycr_dmem_pkg::MEM_RESP_NOTRDY;
        end else if (req_i) begin
            resp_q <= acc_ok ? ycr_dmem_pkg::MEM_RESP_RDY_OK : ycr_dmem_pkg::MEM_RESP_RDY_ER;
        end else begin
            resp_q <= ycr_dmem_pkg::MEM_RESP_NOTRDY;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i) begin
            rdata_q <= rd_word;
        end
    end

    assign rsp_o.resp  = resp_q;
    assign rsp_o.rdata = rdata_q;
    assign timer_val_o = mtime_q;
    assign timer_irq_o = irq_q;

endmodule

//--- verilog/tcm_ram.sv
`timescale 1ns/1ps

module tcm_ram (
    input  logic                    clk,
    input  logic                    req_i,
    input  ycr_dmem_pkg::dmem_req_t req_data_i,
    output ycr_dmem_pkg::dmem_rsp_t rsp_o,
    input  logic                    arst_n_i
);

    // Word-organized array
    logic [ycr_dmem_pkg::DMEM_DWIDTH-1:0] mem [0:ycr_dmem_pkg::TCM_WORDS-1];

    logic [ycr_dmem_pkg::TCM_IDX_W-1:0]   word_idx;
    logic [ycr_dmem_pkg::DMEM_NBYTES-1:0] byte_en;
    logic                                 wr_en;

    ycr_dmem_pkg::mem_resp_e              resp_q;
    logic [ycr_dmem_pkg::DMEM_DWIDTH-1:0] rdata_q;

    // Word index from addr[11:2]
    assign word_idx = req_data_i.addr[ycr_dmem_pkg::TCM_IDX_W+1:2];
    assign wr_en    = req_i & (req_data_i.cmd == ycr_dmem_pkg::MEM_CMD_WR);

    // Byte lanes from width and low address bits
    always_comb begin
        case (req_data_i.width)
            ycr_dmem_pkg::MEM_WIDTH_BYTE:  byte_en = 4'b0001 << req_data_i.addr[1:0];
            ycr_dmem_pkg::MEM_WIDTH_HWORD: byte_en = 4'b0011 << {req_data_i.addr[1], 1'b0};
            default:                       byte_en = 4'b1111;
        endcase
    end

    // -----------------------------------------------
    // Array write and registered read
    // -----------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < ycr_dmem_pkg::DMEM_NBYTES; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx][8*i +: 8] <= req_data_i.wdata[8*i +: 8];
                end
            end
        end
        // Full word back, requester picks its lanes
        if (req_i) begin
            rdata_q <= mem[word_idx];
        end
    end

    // Always ready-ok one cycle after strobe
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_q <= ycr_dmem_pkg::MEM_RESP_NOTRDY;
        end else if (req_i) begin
            resp_q <= ycr_dmem_pkg::MEM_RESP_RDY_OK;
        end else begin
            resp_q <= ycr_dmem_pkg::MEM_RESP_NOTRDY;
        end
    end

    assign rsp_o.resp  = resp_q;
    assign rsp_o.rdata = rdata_q;

endmodule

//--- verilog/ycr_dmem_pkg.sv
package ycr_dmem_pkg;

    // -----------------------------------------------
    // Bus widths
    // -----------------------------------------------
    localparam int unsigned DMEM_AWIDTH = 32;
    localparam int unsigned DMEM_DWIDTH = 32;
    // Byte lanes per data word
    localparam int unsigned DMEM_NBYTES = DMEM_DWIDTH / 8;

    // Access direction
    typedef enum logic [0:0] {
        MEM_CMD_RD = 1'b0,
        MEM_CMD_WR = 1'b1
    } mem_cmd_e;

    // Access size
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE  = 2'b00,
        MEM_WIDTH_HWORD = 2'b01,
        MEM_WIDTH_WORD  = 2'b10
    } mem_width_e;

    // Response code, not-ready between responses
    typedef enum logic [1:0] {
        MEM_RESP_NOTRDY = 2'b00,
        MEM_RESP_RDY_OK = 2'b01,
        MEM_RESP_RDY_ER = 2'b10
    } mem_resp_e;

    // Request payload, 67 bits
    typedef struct packed {
        mem_cmd_e                 cmd;
        mem_width_e               width;
        logic [DMEM_AWIDTH-1:0]   addr;
        // Write data already placed on its byte lanes
        logic [DMEM_DWIDTH-1:0]   wdata;
    } dmem_req_t;

    // Response payload, 34 bits
    typedef struct packed {
        mem_resp_e                resp;
        logic [DMEM_DWIDTH-1:0]   rdata;
    } dmem_rsp_t;

    // -----------------------------------------------
    // Address map
    // -----------------------------------------------
    // TCM, 4 KiB
    localparam logic [DMEM_AWIDTH-1:0] TCM_ADDR_MASK      = 32'hFFFF_F000;
    localparam logic [DMEM_AWIDTH-1:0] TCM_ADDR_PATTERN   = 32'h0048_0000;
    // Timer, 32 byte window
    localparam logic [DMEM_AWIDTH-1:0] TIMER_ADDR_MASK    = 32'hFFFF_FFE0;
    localparam logic [DMEM_AWIDTH-1:0] TIMER_ADDR_PATTERN = 32'h0049_0000;

    // TCM geometry
    localparam int unsigned TCM_WORDS = 1024;
    localparam int unsigned TCM_IDX_W = 10;

    // Timer register offsets inside its window
    localparam logic [4:0] TIMER_CTRL_OFS        = 5'h00;
    localparam logic [4:0] TIMER_MTIME_LO_OFS    = 5'h08;
    localparam logic [4:0] TIMER_MTIME_HI_OFS    = 5'h0C;
    localparam logic [4:0] TIMER_MTIMECMP_LO_OFS = 5'h10;
    localparam logic [4:0] TIMER_MTIMECMP_HI_OFS = 5'h14;

    // Machine timer value
    typedef logic [63:0] mtime_t;

endpackage

//--- verilog/ycr_dmem_top.sv
`timescale 1ns/1ps

module ycr_dmem_top (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic                    rtc_clk_i,
    // Data-memory request port
    input  logic                    req_i,
    input  ycr_dmem_pkg::dmem_req_t req_data_i,
    output logic                    req_ack_o,
    output ycr_dmem_pkg::dmem_rsp_t rsp_o,
    // Timer outputs
    output ycr_dmem_pkg::mtime_t    timer_val_o,
    output logic                    timer_irq_o
);

    // -----------------------------------------------
    // Router to target wiring
    // -----------------------------------------------
    ycr_dmem_pkg::dmem_req_t tgt_req;
    logic                    tcm_req;
    logic                    timer_req;
    ycr_dmem_pkg::dmem_rsp_t tcm_rsp;
    ycr_dmem_pkg::dmem_rsp_t timer_rsp;

    dmem_router i_dmem_router (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .req_data_i  (req_data_i),
        .req_ack_o   (req_ack_o),
        .rsp_o       (rsp_o),
        .tgt_req_o   (tgt_req),
        .tcm_req_o   (tcm_req),
        .timer_req_o (timer_req),
        .tcm_rsp_i   (tcm_rsp),
        .timer_rsp_i (timer_rsp)
    );

    // 4 KiB data TCM
    tcm_ram i_tcm (
        .clk        (clk),
        .req_i      (tcm_req),
        .req_data_i (tgt_req),
        .rsp_o      (tcm_rsp),
        .arst_n_i   (arst_n_i)
    );

    // Memory-mapped machine timer
    mtimer i_timer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rtc_clk_i   (rtc_clk_i),
        .req_i       (timer_req),
        .req_data_i  (tgt_req),
        .rsp_o       (timer_rsp),
        .timer_val_o (timer_val_o),
        .timer_irq_o (timer_irq_o)
    );

endmodule

//--- ycr_dmem_cluster.f
verilog/ycr_dmem_pkg.sv
verilog/dmem_router.sv
verilog/tcm_ram.sv
verilog/mtimer.sv
verilog/ycr_dmem_top.sv
bench/ycr_dmem_sva.sv
bench/tb_ycr_dmem_top.sv
